// ==== verilog.f ====
+incdir+.
regfile_pkg.sv
regfile_bank.sv
regfile_write_stage.sv
regfile_read_check.sv
parity_regfile_top.sv
parity_regfile_properties.sv
tb_parity_regfile.sv

// ==== tb_parity_regfile.sv ====
// Parity register file testbench

`timescale 1ns/1ps

`include "regfile_consts.svh"

module tb_parity_regfile import regfile_pkg::*; ();

    localparam int CLK_PERIOD      = 40;
    localparam int DRIVE_DELAY     = 2;
    localparam int RESET_CYCLES    = 16;
    localparam int DIRECTED_CYCLES = 16;
    localparam int RANDOM_CYCLES   = 600;
    localparam int BURST_READS     = 270;
    localparam int TIMEOUT_CYCLES  = RESET_CYCLES + `RF_DEPTH + DIRECTED_CYCLES
                                     + RANDOM_CYCLES + BURST_READS + 64;
    localparam logic [31:0] SEED   = 32'ha9b4;

    logic                     clk;
    logic                     rst;
    logic                     wr_en;
    rf_addr_t                 wr_addr;
    rf_word_t                 wr_data;
    logic                     wr_inject;
    logic                     rd_en;
    rf_addr_t                 rd_addr;
    logic                     rd_valid;
    rf_word_t                 rd_data;
    rf_par_t                  rd_err;
    logic [`RF_ERR_CNT_W-1:0] err_count;
    rf_addr_t                 err_addr;

    // Reference model of the register contents
    rf_word_t model_data [`RF_DEPTH];
    logic     model_inj  [`RF_DEPTH];

    // Write sampled at the previous edge, lands in the banks at the next one
    logic     pend_we;
    rf_addr_t pend_addr;
    rf_word_t pend_data;
    logic     pend_inj;

    // Predicted outputs
    logic                     exp_valid;
    rf_word_t                 exp_data;
    rf_par_t                  exp_err;
    logic [`RF_ERR_CNT_W-1:0] exp_count;
    rf_addr_t                 exp_err_addr;

    int data_errs  = 0;
    int ctrl_errs  = 0;
    int stat_errs  = 0;
    int cycle_count = 0;

    parity_regfile_top parity_regfile_top_i (
        .clk       (clk),
        .rst       (rst),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_inject (wr_inject),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_valid  (rd_valid),
        .rd_data   (rd_data),
        .rd_err    (rd_err),
        .err_count (err_count),
        .err_addr  (err_addr)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Run stopped after %0d cycles before the stimulus finished", cycle_count);
            $display("test failed");
            $finish;
        end
    end

    task automatic check_field(input string name, input logic [31:0] expected,
                               input logic [31:0] actual, ref int errs);
        assert (actual === expected) else begin
            $display("[ERROR] %0t ns %s expected 'h%0h got 'h%0h",
                     $time, name, expected, actual);
            errs++;
        end
    endtask

    // Drive one cycle, advance the model across the edge, then compare
    task automatic run_cycle(input logic we, input rf_addr_t wa, input rf_word_t wd,
                             input logic wi, input logic re, input rf_addr_t ra);
        wr_en     = we;
        wr_addr   = wa;
        wr_data   = wd;
        wr_inject = wi;
        rd_en     = re;
        rd_addr   = ra;
        @(posedge clk);
        // Read sees the banks before this edge's write lands
        exp_valid = re;
        exp_err   = '0;
        if (re) begin
            exp_data = model_data[ra];
            if (model_inj[ra]) begin
                exp_err[0]   = 1'b1;
                exp_err_addr = ra;
                if (exp_count != '1) begin
                    exp_count = exp_count + 1'b1;
                end
            end
        end
        if (pend_we) begin
            model_data[pend_addr] = pend_data;
            model_inj[pend_addr]  = pend_inj;
        end
        pend_we   = we;
        pend_addr = wa;
        pend_data = wd;
        pend_inj  = wi;
        #(DRIVE_DELAY);
        check_field("rd_valid", exp_valid, rd_valid, ctrl_errs);
        if (exp_valid) begin
            check_field("rd_data", exp_data, rd_data, data_errs);
        end
        check_field("rd_err", exp_err, rd_err, ctrl_errs);
        check_field("err_count", exp_count, err_count, stat_errs);
        check_field("err_addr", exp_err_addr, err_addr, stat_errs);
    endtask

    task automatic write_word(input rf_addr_t addr, input rf_word_t data, input logic inject);
        run_cycle(1'b1, addr, data, inject, 1'b0, '0);
    endtask

    task automatic read_word(input rf_addr_t addr);
        run_cycle(1'b0, '0, '0, 1'b0, 1'b1, addr);
    endtask

    task automatic idle_cycle();
        run_cycle(1'b0, '0, '0, 1'b0, 1'b0, '0);
    endtask

    task automatic random_cycle();
        logic     we;
        logic     wi;
        logic     re;
        rf_addr_t wa;
        rf_addr_t ra;
        rf_word_t wd;
        we = ($urandom_range(99) < 50);
        wa = rf_addr_t'($urandom());
        wd = rf_word_t'($urandom());
        // Inject also appears without wr_en, where it must be ignored
        wi = ($urandom_range(99) < 10);
        re = ($urandom_range(99) < 60);
        ra = rf_addr_t'($urandom());
        run_cycle(we, wa, wd, wi, re, ra);
    endtask

    initial begin
        int total;
        void'($urandom(SEED));
        rst       = 1'b1;
        wr_en     = 1'b0;
        wr_addr   = '0;
        wr_data   = '0;
        wr_inject = 1'b0;
        rd_en     = 1'b0;
        rd_addr   = '0;
        for (int a = 0; a < `RF_DEPTH; a++) begin
            model_data[a] = '0;
            model_inj[a]  = 1'b0;
        end
        pend_we      = 1'b0;
        pend_addr    = '0;
        pend_data    = '0;
        pend_inj     = 1'b0;
        exp_valid    = 1'b0;
        exp_data     = '0;
        exp_err      = '0;
        exp_count    = '0;
        exp_err_addr = '0;

        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY);
        rst = 1'b0;

        // Every entry reads back as zero after reset
        for (int a = 0; a < `RF_DEPTH; a++) begin
            read_word(rf_addr_t'(a));
        end

        // One cycle after the write the old word, two cycles after the new one
        write_word(rf_addr_t'(5), rf_word_t'($urandom()), 1'b0);
        read_word(rf_addr_t'(5));
        read_word(rf_addr_t'(5));

        // Injected fault, then a clean rewrite of the same address
        write_word(rf_addr_t'(9), rf_word_t'($urandom()), 1'b1);
        idle_cycle();
        read_word(rf_addr_t'(9));
        read_word(rf_addr_t'(9));
        write_word(rf_addr_t'(9), rf_word_t'($urandom()), 1'b0);
        idle_cycle();
        read_word(rf_addr_t'(9));

        repeat (RANDOM_CYCLES) random_cycle();

        // Long burst of failing reads drives the counter into saturation
        write_word(rf_addr_t'(12), rf_word_t'($urandom()), 1'b1);
        idle_cycle();
        repeat (BURST_READS) read_word(rf_addr_t'(12));
        idle_cycle();
        check_field("err_count", 32'hff, err_count, stat_errs);

        total = data_errs + ctrl_errs + stat_errs + parity_regfile_top_i.props_i.fail_count;
        $display("Errors: data %0d, control %0d, statistics %0d, assertions %0d",
                 data_errs, ctrl_errs, stat_errs, parity_regfile_top_i.props_i.fail_count);
        if (total == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== parity_regfile_properties.sv ====
// Read port assertions

`timescale 1ns/1ps

`include "regfile_consts.svh"

module parity_regfile_properties import regfile_pkg::*; (
    input logic                     clk,
    input logic                     rst,
    input logic                     rd_en,
    input logic                     rd_valid,
    input rf_par_t                  rd_err,
    input logic [`RF_ERR_CNT_W-1:0] err_count
);

    // Number of failed assertions
    int fail_count = 0;

    // Two valid cycles in a row need two read strobes in a row
    valid_follows_rd_en: assert property (
        @(posedge clk) disable iff (rst)
        (rd_valid && $past(rd_valid)) |-> ($past(rd_en) && $past(rd_en, 2))
    ) else begin
        $error("rd_valid high for two cycles without two read strobes");
        fail_count++;
    end

    count_monotonic: assert property (
        @(posedge clk) disable iff (rst)
        err_count >= $past(err_count)
    ) else begin
        $error("err_count decreased outside reset");
        fail_count++;
    end

    // Mask only carries meaning alongside a valid read
    err_needs_valid: assert property (
        @(posedge clk)
        !rd_valid |-> (rd_err == '0)
    ) else begin
        $error("rd_err nonzero while rd_valid is low");
        fail_count++;
    end

    valid_low_in_reset: assert property (
        @(posedge clk)
        (rst && $past(rst)) |-> !rd_valid
    ) else begin
        $error("rd_valid high during reset");
        fail_count++;
    end

endmodule

bind parity_regfile_top parity_regfile_properties props_i (
    .clk       (clk),
    .rst       (rst),
    .rd_en     (rd_en),
    .rd_valid  (rd_valid),
    .rd_err    (rd_err),
    .err_count (err_count)
);

// ==== parity_regfile_top.sv ====
// Parity protected register file

`timescale 1ns/1ps

`include "regfile_consts.svh"

module parity_regfile_top import regfile_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,

    // Write port
    input  logic                     wr_en,
    input  rf_addr_t                 wr_addr,
    input  rf_word_t                 wr_data,
    input  logic                     wr_inject,

    // Read port
    input  logic                     rd_en,
    input  rf_addr_t                 rd_addr,
    output logic                     rd_valid,
    output rf_word_t                 rd_data,
    output rf_par_t                  rd_err,

    // Error statistics
    output logic [`RF_ERR_CNT_W-1:0] err_count,
    output rf_addr_t                 err_addr
);

    rf_wr_req_t wr_req;
    rf_word_t   rd_word;
    rf_par_t    rd_par;

    regfile_write_stage u_write_stage (
        .clk       (clk),
        .rst       (rst),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_inject (wr_inject),
        .wr_req    (wr_req)
    );

    // Data words
    regfile_bank #(
        .payload_t (rf_word_t)
    ) u_data_bank (
        .clk   (clk),
        .rst   (rst),
        .we    (wr_req.valid),
        .waddr (wr_req.addr),
        .wdata (wr_req.data),
        .raddr (rd_addr),
        .rdata (rd_word)
    );

    // Parity bits, written in the same cycle as the data
    regfile_bank #(
        .payload_t (rf_par_t)
    ) u_parity_bank (
        .clk   (clk),
        .rst   (rst),
        .we    (wr_req.valid),
        .waddr (wr_req.addr),
        .wdata (wr_req.par),
        .raddr (rd_addr),
        .rdata (rd_par)
    );

    regfile_read_check u_read_check (
        .clk       (clk),
        .rst       (rst),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_word   (rd_word),
        .rd_par    (rd_par),
        .rd_valid  (rd_valid),
        .rd_data   (rd_data),
        .rd_err    (rd_err),
        .err_count (err_count),
        .err_addr  (err_addr)
    );

endmodule

// ==== regfile_read_check.sv ====
// Parity register file read checker

`timescale 1ns/1ps

`include "regfile_consts.svh"

module regfile_read_check import regfile_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,

    // Read strobe and address, sampled at the rising edge
    input  logic                     rd_en,
    input  rf_addr_t                 rd_addr,

    // Bank outputs for rd_addr
    input  rf_word_t                 rd_word,
    input  rf_par_t                  rd_par,

    // Checked read, valid for one cycle
    output logic                     rd_valid,
    output rf_word_t                 rd_data,
    output rf_par_t                  rd_err,

    // Error statistics
    output logic [`RF_ERR_CNT_W-1:0] err_count,
    output rf_addr_t                 err_addr
);

    // Bytes whose recomputed parity differs from the stored bit
    rf_par_t par_mismatch;

    // This read has at least one bad byte
    logic    read_fail;

    // Counter already at its limit
    logic    count_full;

    assign par_mismatch = rf_byte_parity(rd_word) ^ rd_par;
    assign read_fail    = rd_en && (par_mismatch != '0);
    assign count_full   = &err_count;

    // Valid pulse and error mask
    // Mask is forced to zero on idle cycles
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid <= 1'b0;
            rd_err   <= '0;
        end else begin
            rd_valid <= rd_en;
            rd_err   <= rd_en ? par_mismatch : '0;
        end
    end

    // Read data is passed through unchanged, errors are not corrected
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= rd_word;
        end
    end

    // Statistics move on the same edge as rd_valid
    always_ff @(posedge clk) begin
        if (rst) begin
            err_count <= '0;
            err_addr  <= '0;
        end else if (read_fail) begin
            err_addr <= rd_addr;
            // Saturate instead of wrapping
            if (!count_full) begin
                err_count <= err_count + 1'b1;
            end
        end
    end

endmodule

// ==== regfile_write_stage.sv ====
// Parity register file write stage

`timescale 1ns/1ps

module regfile_write_stage import regfile_pkg::*; (
    input  logic       clk,
    input  logic       rst,

    // Write strobe and payload from outside
    input  logic       wr_en,
    input  rf_addr_t   wr_addr,
    input  rf_word_t   wr_data,

    // Store byte 0 parity inverted
    input  logic       wr_inject,

    // Registered request to both banks
    output rf_wr_req_t wr_req
);

    // Parity of the incoming word
    rf_par_t  par_calc;

    // Parity after optional fault injection
    rf_par_t  par_store;

    // Registered request fields
    logic     req_valid;
    rf_addr_t req_addr;
    rf_word_t req_data;
    rf_par_t  req_par;

    assign par_calc = rf_byte_parity(wr_data);

    // Injection only flips byte 0, other bytes stay correct
    always_comb begin
        par_store = par_calc;
        if (wr_inject) begin
            par_store[0] = ~par_calc[0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            req_valid <= 1'b0;
        end else begin
            req_valid <= wr_en;
        end
    end

    // Payload only loads on an accepted write
    always_ff @(posedge clk) begin
        if (wr_en) begin
            req_addr <= wr_addr;
            req_data <= wr_data;
            req_par  <= par_store;
        end
    end

    assign wr_req = '{
        valid: req_valid,
        addr:  req_addr,
        data:  req_data,
        par:   req_par
    };

endmodule

// ==== regfile_bank.sv ====
// Register file storage bank

`timescale 1ns/1ps

`include "regfile_consts.svh"

module regfile_bank import regfile_pkg::*; #(
    // Payload held in each entry
    parameter type payload_t = rf_word_t
) (
    input  logic     clk,
    input  logic     rst,

    // Write side, driven by the registered write request
    input  logic     we,
    input  rf_addr_t waddr,
    input  payload_t wdata,

    // Read side, combinational lookup
    input  rf_addr_t raddr,
    output payload_t rdata
);

    // One entry per register address
    payload_t mem [`RF_DEPTH];

    // All entries clear to zero on reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RF_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Asynchronous read
    // The checker registers the result one edge later
    assign rdata = mem[raddr];

endmodule

// ==== regfile_pkg.sv ====
// Parity register file types

`include "regfile_consts.svh"

package regfile_pkg;

    // Data word as held in the data bank
    typedef logic [`RF_DATA_W-1:0] rf_word_t;

    // Parity vector, bit n covers byte n of the word
    typedef logic [`RF_BYTES-1:0] rf_par_t;

    // Register address
    typedef logic [`RF_ADDR_W-1:0] rf_addr_t;

    // Registered write request sent to both banks
    typedef struct packed {
        logic     valid;
        rf_addr_t addr;
        rf_word_t data;
        rf_par_t  par;
    } rf_wr_req_t;

    // Even parity per byte, each bit is the XOR of its byte
    function automatic rf_par_t rf_byte_parity(input rf_word_t word);
        rf_par_t par;
        par = '0;
        for (int b = 0; b < `RF_BYTES; b++) begin
            par[b] = ^word[b*8 +: 8];
        end
        return par;
    endfunction

endpackage

// ==== regfile_consts.svh ====
// Parity register file constants

`ifndef REGFILE_CONSTS_SVH
`define REGFILE_CONSTS_SVH

// Width of one stored data word
`define RF_DATA_W 16

// Register address width
`define RF_ADDR_W 4

// One even-parity bit per byte of the data word
`define RF_BYTES (`RF_DATA_W / 8)

// Number of registers in each bank
`define RF_DEPTH (1 << `RF_ADDR_W)

// Width of the saturating read error counter
`define RF_ERR_CNT_W 8

`endif
